//--- common/bulk_consts.svh
`ifndef BULK_CONSTS_SVH
`define BULK_CONSTS_SVH

// Byte capacity of the packet buffer that stands in for the DDR3 store
`define SRAM_BYTES 2048

// Bytes per memory word
`define WORD_BYTES 4

`define SRAM_WORDS (`SRAM_BYTES / `WORD_BYTES)  // Capacity in words

// Word address width as log2 of the word capacity
`define ADDR_BITS 9

// Largest bulk packet accepted (high-speed bulk limit)
`define MAX_PACKET_LENGTH 512

`endif

//--- common/bulk_pkg.sv
`default_nettype none

`include "bulk_consts.svh"

package bulk_pkg;

  // Stream and memory payload widths
  typedef logic [7:0] byte_t;
  typedef logic [8*`WORD_BYTES-1:0] word_t;
  typedef logic [`WORD_BYTES-1:0] keep_t;  // One bit per byte lane

  // SRAM addressing and fill level
  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`ADDR_BITS:0] level_t;  // Needs one more bit to reach full

  typedef logic [7:0] pkt_count_t;  // Complete packets held

  // FILL gathers bytes in the packer and HOLD offers a finished word
  typedef enum logic {
    FILL,
    HOLD
  } packer_state_e;

  // IDLE means the unpacker has no word and EMIT sends bytes of the held word
  typedef enum logic {
    IDLE,
    EMIT
  } unpacker_state_e;

endpackage

`default_nettype wire

//--- common/word_stream_if.sv
`default_nettype none

interface word_stream_if import bulk_pkg::*; ();

  logic  tvalid;
  logic  tready;
  word_t tdata;
  keep_t tkeep;  // Low bytes valid and only partial on the last word
  logic  tlast;

  // Producer side of the word stream
  modport source(
    output tvalid,
    output tdata,
    output tkeep,
    output tlast,
    input  tready
  );

  // Consumer side
  modport sink(
    input  tvalid,
    input  tdata,
    input  tkeep,
    input  tlast,
    output tready
  );

endinterface

`default_nettype wire

//--- packet_buffer/buffer_sram.sv
`default_nettype none

`include "bulk_consts.svh"

module buffer_sram import bulk_pkg::*; #(
  parameter int DATA_BITS = 37  // Word, keep mask and last flag
) (
  input  wire logic                  clock,
  input  wire logic                  wr_en_i,
  input  wire addr_t                 wr_addr_i,
  input  wire logic [DATA_BITS-1:0]  wr_data_i,
  input  wire logic                  rd_en_i,
  input  wire addr_t                 rd_addr_i,
  output logic      [DATA_BITS-1:0]  rd_data_o
);

  logic [DATA_BITS-1:0] mem [`SRAM_WORDS];

  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read whose output holds between reads
  always_ff @(posedge clock) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

//--- packet_buffer/packet_buffer.sv
`default_nettype none

`include "bulk_consts.svh"

module packet_buffer import bulk_pkg::*; (
  input  wire logic     clock,
  input  wire logic     rst_i,
  word_stream_if.sink   rx_words,
  word_stream_if.source tx_words,
  output pkt_count_t    pkt_count_o,
  output level_t        level_o
);

  localparam int ENTRY_BITS    = $bits(word_t) + $bits(keep_t) + 1;
  localparam int MAX_PKT_WORDS = `MAX_PACKET_LENGTH / `WORD_BYTES;

  addr_t      wr_ptr_q, rd_ptr_q;
  level_t     level_q;      // Words written and not yet sent on tx_words
  level_t     in_words_q;   // Words so far in the incoming packet
  pkt_count_t pkt_count_q;  // Complete packets held
  pkt_count_t rd_avail_q;   // Complete packets whose last word is still in the SRAM stage

  logic                  rd_pend_q;  // SRAM output holds a fetched entry
  logic                  out_valid_q;
  word_t                 out_data_q;
  keep_t                 out_keep_q;
  logic                  out_last_q;
  logic [ENTRY_BITS-1:0] wr_entry, rd_entry;

  logic rx_xfer, tx_xfer, rd_en, stage_move, stage_last;

  assign rx_words.tready = (level_q != level_t'(`SRAM_WORDS)) && !(&pkt_count_q);
  assign rx_xfer  = rx_words.tvalid && rx_words.tready;
  assign tx_xfer  = tx_words.tvalid && tx_words.tready;
  assign wr_entry = {rx_words.tdata, rx_words.tkeep, rx_words.tlast};

  // Fetched entry moves on when the output register is free or draining
  assign stage_move = rd_pend_q && (!out_valid_q || tx_words.tready);
  assign stage_last = rd_entry[0];

  // Fetch only inside a complete packet, never past its last word
  assign rd_en = (rd_avail_q != '0) && (!rd_pend_q || (stage_move && !stage_last));

  buffer_sram #(
    .DATA_BITS(ENTRY_BITS)
  ) sram0 (
    .clock    (clock),
    .wr_en_i  (rx_xfer),
    .wr_addr_i(wr_ptr_q),
    .wr_data_i(wr_entry),
    .rd_en_i  (rd_en),
    .rd_addr_i(rd_ptr_q),
    .rd_data_o(rd_entry)
  );

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      level_q     <= '0;
      in_words_q  <= '0;
      pkt_count_q <= '0;
      rd_avail_q  <= '0;
      rd_pend_q   <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (rx_xfer) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (rx_xfer) in_words_q <= rx_words.tlast ? '0 : in_words_q + 1'b1;
      level_q <= level_q + level_t'(rx_xfer) - level_t'(tx_xfer);
      pkt_count_q <= pkt_count_q + pkt_count_t'(rx_xfer && rx_words.tlast)
                     - pkt_count_t'(tx_xfer && tx_words.tlast);
      rd_avail_q <= rd_avail_q + pkt_count_t'(rx_xfer && rx_words.tlast)
                    - pkt_count_t'(stage_move && stage_last);
      if (rd_en) rd_pend_q <= 1'b1;
      else if (stage_move) rd_pend_q <= 1'b0;
      if (stage_move) out_valid_q <= 1'b1;
      else if (tx_words.tready) out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (stage_move) begin
      {out_data_q, out_keep_q, out_last_q} <= rd_entry;
    end
  end

  assign tx_words.tvalid = out_valid_q;
  assign tx_words.tdata  = out_data_q;
  assign tx_words.tkeep  = out_keep_q;
  assign tx_words.tlast  = out_last_q;

  assign pkt_count_o = pkt_count_q;
  assign level_o     = level_q;

  a_level_max: assert property (@(posedge clock) disable iff (rst_i)
    level_q <= level_t'(`SRAM_WORDS));

  // Words still unread in the SRAM are level minus those in the output pipe
  a_no_empty_read: assert property (@(posedge clock) disable iff (rst_i)
    rd_en |-> level_q > (level_t'(rd_pend_q) + level_t'(out_valid_q)));

  a_pkt_length: assert property (@(posedge clock) disable iff (rst_i)
    rx_xfer |-> in_words_q < level_t'(MAX_PKT_WORDS));

endmodule

`default_nettype wire

//--- source/bulk_rx_packer.sv
`default_nettype none

module bulk_rx_packer import bulk_pkg::*; (
  input  wire logic     clock,
  input  wire logic     rst_i,
  input  wire logic     s_tvalid_i,
  input  wire logic     s_tlast_i,
  input  wire byte_t    s_tdata_i,
  output logic          s_tready_o,
  word_stream_if.source rx_words
);

  packer_state_e state_q;
  logic [1:0]    pos_q;   // Byte lane for the next accepted byte
  word_t         data_q;
  keep_t         keep_q;
  logic          last_q;

  logic  s_xfer;
  logic  word_full;
  keep_t lane_bit;

  assign s_tready_o = (state_q == FILL);
  assign s_xfer     = s_tvalid_i && s_tready_o;
  assign word_full  = (pos_q == 2'd3) || s_tlast_i;  // Word closes on lane 3 or on tlast
  assign lane_bit   = keep_t'(1) << pos_q;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q <= FILL;
      pos_q   <= 2'd0;
    end else begin
      case (state_q)
        FILL: begin
          if (s_xfer) begin
            pos_q <= word_full ? 2'd0 : pos_q + 2'd1;
            if (word_full) state_q <= HOLD;
          end
        end
        HOLD: begin
          if (rx_words.tready) state_q <= FILL;
        end
        default: state_q <= FILL;
      endcase
    end
  end

  // A new word restarts the keep mask at lane 0
  always_ff @(posedge clock) begin
    if (s_xfer) begin
      data_q[{pos_q, 3'b000} +: 8] <= s_tdata_i;
      keep_q <= (pos_q == 2'd0) ? lane_bit : (keep_q | lane_bit);
      last_q <= s_tlast_i;
    end
  end

  assign rx_words.tvalid = (state_q == HOLD);
  assign rx_words.tdata  = data_q;
  assign rx_words.tkeep  = keep_q;
  assign rx_words.tlast  = last_q;

  // Offered word must stay put until the buffer takes it
  a_rx_hold: assert property (@(posedge clock) disable iff (rst_i)
    rx_words.tvalid && !rx_words.tready |=>
      rx_words.tvalid && $stable(rx_words.tdata) && $stable(rx_words.tkeep)
      && $stable(rx_words.tlast));

endmodule

`default_nettype wire

//--- source/bulk_tx_unpacker.sv
`default_nettype none

module bulk_tx_unpacker import bulk_pkg::*; (
  input  wire logic   clock,
  input  wire logic   rst_i,
  word_stream_if.sink tx_words,
  output logic        m_tvalid_o,
  input  wire logic   m_tready_i,
  output logic        m_tlast_o,
  output byte_t       m_tdata_o
);

  unpacker_state_e state_q;
  word_t           data_q;
  keep_t           keep_q;
  logic            last_q;
  logic [1:0]      idx_q;  // Lane of the byte on m_tdata_o

  logic is_final, m_xfer, word_done, word_xfer;

  // Keep is contiguous from lane 0, so the next clear bit ends the word
  assign is_final  = (idx_q == 2'd3) || !keep_q[idx_q + 2'd1];
  assign m_xfer    = m_tvalid_o && m_tready_i;
  assign word_done = m_xfer && is_final;

  assign tx_words.tready = (state_q == IDLE) || word_done;  // Refill as the last byte goes
  assign word_xfer = tx_words.tvalid && tx_words.tready;

  assign m_tvalid_o = (state_q == EMIT);
  assign m_tdata_o  = data_q[{idx_q, 3'b000} +: 8];
  assign m_tlast_o  = m_tvalid_o && last_q && is_final;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q <= IDLE;
      idx_q   <= 2'd0;
    end else begin
      if (word_xfer) begin
        state_q <= EMIT;
        idx_q   <= 2'd0;
      end else if (word_done) begin
        state_q <= IDLE;
      end else if (m_xfer) begin
        idx_q <= idx_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (word_xfer) begin
      data_q <= tx_words.tdata;
      keep_q <= tx_words.tkeep;
      last_q <= tx_words.tlast;
    end
  end

  // A byte once offered stays offered until the host side takes it
  a_m_hold: assert property (@(posedge clock) disable iff (rst_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o));

endmodule

`default_nettype wire

//--- source/bulk_bridge_top.sv
`default_nettype none

module bulk_bridge_top import bulk_pkg::*; (
  input  wire logic       clock,
  input  wire logic       rst_i,

  // Bulk OUT byte stream from the host
  input  wire logic       s_tvalid_i,
  output wire logic       s_tready_o,
  input  wire logic       s_tlast_i,
  input  wire byte_t      s_tdata_i,

  // Bulk IN byte stream toward the host
  output wire logic       m_tvalid_o,
  input  wire logic       m_tready_i,
  output wire logic       m_tlast_o,
  output wire byte_t      m_tdata_o,

  output wire pkt_count_t pkt_count_o,  // Status of the store-and-forward buffer
  output wire level_t     level_o
);

  word_stream_if rx_words ();
  word_stream_if tx_words ();

  bulk_rx_packer packer0 (
    .clock     (clock),
    .rst_i     (rst_i),
    .s_tvalid_i(s_tvalid_i),
    .s_tlast_i (s_tlast_i),
    .s_tdata_i (s_tdata_i),
    .s_tready_o(s_tready_o),
    .rx_words  (rx_words.source)
  );

  packet_buffer buffer0 (
    .clock      (clock),
    .rst_i      (rst_i),
    .rx_words   (rx_words.sink),
    .tx_words   (tx_words.source),
    .pkt_count_o(pkt_count_o),
    .level_o    (level_o)
  );

  bulk_tx_unpacker unpacker0 (
    .clock     (clock),
    .rst_i     (rst_i),
    .tx_words  (tx_words.sink),
    .m_tvalid_o(m_tvalid_o),
    .m_tready_i(m_tready_i),
    .m_tlast_o (m_tlast_o),
    .m_tdata_o (m_tdata_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clock_o,
  output logic rst_o
);

  initial begin
    clock_o = 1'b0;
    forever #5 clock_o = ~clock_o;  // Period of 10
  end

  // Reset spans three rising edges and is released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clock_o);
    @(negedge clock_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/tb_bulk_bridge.sv
`default_nettype none

`include "bulk_consts.svh"

module tb_bulk_bridge;

  localparam int NUM_PKTS     = 16;
  localparam int MODE_ALWAYS  = 0;
  localparam int MODE_RANDOM  = 1;
  localparam int MODE_HELD    = 2;
  localparam int QUIET_CYCLES = 20;

  logic                clock, rst_i;
  logic                s_tvalid_i, s_tready_o, s_tlast_i;
  logic [7:0]          s_tdata_i;
  logic                m_tvalid_o, m_tready_i, m_tlast_o;
  logic [7:0]          m_tdata_o;
  logic [7:0]          pkt_count_o;
  logic [`ADDR_BITS:0] level_o;

  // One row of the packet table per packet in send order
  string pkt_name[NUM_PKTS];
  int    pkt_len[NUM_PKTS];
  int    pkt_first[NUM_PKTS];
  int    pkt_stride[NUM_PKTS];
  int    pkt_mode[NUM_PKTS];
  int    table_rows;

  logic [8:0] model_q[$];  // {last, byte} in acceptance order
  int         errors, checks, cycles, cycle_limit;
  int         in_pkts_done, out_pkts_done, tlast_seen, ready_mode;
  integer     seed = 12077;
  logic       saw_full_stall;

  tb_clock_gen clkgen0 (.clock_o(clock), .rst_o(rst_i));

  bulk_bridge_top dut0 (
    .clock      (clock),
    .rst_i      (rst_i),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .s_tlast_i  (s_tlast_i),
    .s_tdata_i  (s_tdata_i),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o),
    .pkt_count_o(pkt_count_o),
    .level_o    (level_o)
  );

  task automatic add_row(input string name, input int len, input int first,
                         input int stride, input int mode);
    pkt_name[table_rows]   = name;
    pkt_len[table_rows]    = len;
    pkt_first[table_rows]  = first;
    pkt_stride[table_rows] = stride;
    pkt_mode[table_rows]   = mode;
    table_rows++;
  endtask

  task automatic build_table();
    table_rows = 0;
    add_row("len1", 1, 8'h10, 1, MODE_ALWAYS);
    add_row("len2", 2, 8'h20, 3, MODE_ALWAYS);
    add_row("len3_rand", 3, 8'h30, 5, MODE_RANDOM);
    add_row("len4", 4, 8'h40, 7, MODE_ALWAYS);
    add_row("len5_rand", 5, 8'h50, 1, MODE_RANDOM);
    add_row("len8", 8, 8'h60, 9, MODE_ALWAYS);
    add_row("len512", 512, 8'h00, 1, MODE_ALWAYS);
    add_row("held_7", 7, 8'h70, 2, MODE_HELD);
    add_row("held_12", 12, 8'h80, 3, MODE_HELD);
    add_row("held_33", 33, 8'h90, 5, MODE_HELD);
    // Six full packets outrun a slow host and fill the buffer
    for (int i = 0; i < 6; i++) begin
      add_row($sformatf("fill_%0d", i), 512, 16 * i, 2 * i + 1, MODE_RANDOM);
    end
  endtask

  function automatic logic [7:0] pkt_byte(input int idx, input int k);
    return 8'(pkt_first[idx] + k * pkt_stride[idx]);
  endfunction

  function automatic string name_of(input int idx);
    if (idx < table_rows) return pkt_name[idx];
    return "unexpected packet";
  endfunction

  // Host side ready changes on the falling edge
  always @(negedge clock) begin
    case (ready_mode)
      MODE_RANDOM: m_tready_i = (($random(seed) & 7) == 0);  // About one byte in eight
      MODE_HELD:   m_tready_i = 1'b0;
      default:     m_tready_i = 1'b1;
    endcase
  end

  // Reference model and output checks on the rising edge before outputs update
  always @(posedge clock) begin
    logic [8:0] exp_entry;
    if (!rst_i) begin
      if (m_tvalid_o) begin
        checks++;
        assert (out_pkts_done < in_pkts_done) else begin
          errors++;
          $display("Packet %s left before its last input byte was accepted",
                   name_of(out_pkts_done));
        end
      end
      if (m_tvalid_o && m_tready_i) begin
        if (m_tlast_o) tlast_seen++;
        checks++;
        assert (model_q.size() != 0) else begin
          errors++;
          $display("Output byte %02h arrived with no input byte pending", m_tdata_o);
        end
        if (model_q.size() != 0) begin
          exp_entry = model_q.pop_front();
          checks += 2;
          assert (m_tdata_o == exp_entry[7:0]) else begin
            errors++;
            $display("[FAIL] %s data: expected %02h, actual %02h",
                     name_of(out_pkts_done), exp_entry[7:0], m_tdata_o);
          end
          assert (m_tlast_o == exp_entry[8]) else begin
            errors++;
            $display("[FAIL] %s tlast: expected %0b, actual %0b",
                     name_of(out_pkts_done), exp_entry[8], m_tlast_o);
          end
          if (exp_entry[8]) out_pkts_done++;
        end
      end
      if (s_tvalid_i && s_tready_o) begin
        model_q.push_back({s_tlast_i, s_tdata_i});
        if (s_tlast_i) in_pkts_done++;
      end
      if (!s_tready_o && int'(level_o) == `SRAM_WORDS) saw_full_stall = 1'b1;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the bridge stopped making progress", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic send_packet(input int idx);
    for (int k = 0; k < pkt_len[idx]; k++) begin
      @(negedge clock);
      s_tvalid_i = 1'b1;
      s_tdata_i  = pkt_byte(idx, k);
      s_tlast_i  = (k == pkt_len[idx] - 1);
      do @(posedge clock); while (!s_tready_o);
    end
    @(negedge clock);
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    @(posedge clock);
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Status returns to zero once every queued byte has left
  task automatic wait_drained(input string name);
    do @(negedge clock); while (model_q.size() != 0);
    @(negedge clock);
    check_count({name, " pkt_count"}, 0, int'(pkt_count_o));
    check_count({name, " level"}, 0, int'(level_o));
    @(posedge clock);
  endtask

  task automatic wait_quiet();
    int quiet;
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clock);
      if (s_tready_o) quiet++;
      else quiet = 0;
    end
  endtask

  initial begin
    int total_bytes, held_pkts, held_words;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = 8'h00;
    m_tready_i = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    in_pkts_done = 0;
    out_pkts_done = 0;
    tlast_seen = 0;
    saw_full_stall = 1'b0;
    ready_mode = MODE_ALWAYS;
    build_table();
    total_bytes = 0;
    for (int i = 0; i < table_rows; i++) total_bytes += pkt_len[i];
    cycle_limit = 20 * total_bytes + 1000;

    @(negedge rst_i);
    @(posedge clock);
    check_count("reset m_tvalid", 0, int'(m_tvalid_o));
    check_count("reset s_tready", 1, int'(s_tready_o));
    check_count("reset pkt_count", 0, int'(pkt_count_o));
    check_count("reset level", 0, int'(level_o));

    held_pkts = 0;
    held_words = 0;
    for (int i = 0; i < table_rows; i++) begin
      if (pkt_mode[i] == MODE_HELD && (i == 0 || pkt_mode[i - 1] != MODE_HELD)) begin
        wait_drained(pkt_name[i]);  // Held group starts on an empty buffer
      end
      ready_mode = pkt_mode[i];
      send_packet(i);
      if (pkt_mode[i] == MODE_HELD) begin
        held_pkts++;
        held_words += (pkt_len[i] + 3) / 4;
        if (i == table_rows - 1 || pkt_mode[i + 1] != MODE_HELD) begin
          wait_quiet();
          check_count({pkt_name[i], " held pkt_count"}, held_pkts, int'(pkt_count_o));
          // One word of the group already sits in the unpacker
          check_count({pkt_name[i], " held level"}, held_words - 1, int'(level_o));
          ready_mode = MODE_ALWAYS;
          wait_drained(pkt_name[i]);
          held_pkts = 0;
          held_words = 0;
        end
      end
    end

    wait_drained("final");
    check_count("packets out", table_rows, tlast_seen);
    checks++;
    assert (saw_full_stall) else begin
      errors++;
      $display("The buffer never filled, so s_tready_o never fell on a full buffer");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/bulk_pkg.sv
common/word_stream_if.sv
packet_buffer/buffer_sram.sv
packet_buffer/packet_buffer.sv
source/bulk_rx_packer.sv
source/bulk_tx_unpacker.sv
source/bulk_bridge_top.sv
tests/tb_clock_gen.sv
tests/tb_bulk_bridge.sv

//--- Makefile
TOP := tb_bulk_bridge

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "Test failed"; exit 1; fi
	@if ! grep -q "Simulation passed" sim.log; then echo "No pass line in sim.log"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf obj_dir sim.log
